// ==== rtl/sifhPkg.sv ====
// shared types and default sizes for the SiFH peak finder
// pass and control state enums
`default_nettype none

package sifhPkg;

    // ****************************************
    // enums
    // ****************************************

    // histogram pass of the current sweep
    typedef enum logic {
        PASS_COARSE,
        PASS_FINE
    } passE;

    // sample control FSM states
    typedef enum logic [1:0] {
        ST_COLLECT,
        ST_DRAIN,
        ST_TURN
    } ctrlStateE;

    // ****************************************
    // default sizes
    // ****************************************
    localparam int NP_DEF      = 12;
    localparam int NB_DEF      = 5;
    localparam int PIXELS_DEF  = 4;
    localparam int SAMPLES_DEF = 2;
    localparam int ACQS_DEF    = 16;
    // holds ACQS x SAMPLES hits in one bin
    localparam int COUNT_W_DEF = 6;

endpackage

`default_nettype wire

// ==== rtl/binIf.sv ====
// histogram update bus
// histogram builder to peak detector
`timescale 1ns/100ps
`default_nettype none

interface binIf #(
    parameter int PIX_W   = $clog2(sifhPkg::PIXELS_DEF),
    parameter int NB      = sifhPkg::NB_DEF,
    parameter int COUNT_W = sifhPkg::COUNT_W_DEF
);

    // one strobe per accepted sample
    logic               valid;
    logic [PIX_W-1:0]   pixel;
    logic [NB-1:0]      bin;
    // bin value after the increment
    logic [COUNT_W-1:0] count;

    modport src (
        output valid,
        output pixel,
        output bin,
        output count
    );

    modport dst (
        input valid,
        input pixel,
        input bin,
        input count
    );

endinterface

`default_nettype wire

// ==== rtl/frameControl.sv ====
// frame control FSM
// sample, pixel and acquisition counters with pass turn strobes
`timescale 1ns/100ps
`default_nettype none

module frameControl #(
    parameter int PIXELS    = sifhPkg::PIXELS_DEF,
    parameter int SAMPLES   = sifhPkg::SAMPLES_DEF,
    parameter int ACQS      = sifhPkg::ACQS_DEF,
    localparam int PIX_W    = (PIXELS > 1) ? $clog2(PIXELS) : 1,
    localparam int SMP_W    = (SAMPLES > 1) ? $clog2(SAMPLES) : 1,
    localparam int ACQ_W    = (ACQS > 1) ? $clog2(ACQS) : 1
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 wrEn,
    output logic                 ready,
    output logic                 accept,
    output logic [PIX_W-1:0]     pixel,
    output sifhPkg::passE        pass,
    output logic                 passEnd,
    output logic                 clearStat
);

    sifhPkg::ctrlStateE state;
    logic [SMP_W-1:0]   sampleCnt;
    logic [ACQ_W-1:0]   acqCnt;
    logic [1:0]         drainCnt;
    logic               lastSample;
    logic               lastPixel;
    logic               lastAcq;

    // ****************************************
    // strobes and levels
    // ****************************************
    assign ready      = (state == sifhPkg::ST_COLLECT);
    assign accept     = wrEn & ready;
    // turn lasts one cycle
    assign passEnd    = (state == sifhPkg::ST_TURN);
    assign clearStat  = passEnd;

    assign lastSample = (sampleCnt == SMP_W'(SAMPLES - 1));
    assign lastPixel  = (pixel == PIX_W'(PIXELS - 1));
    assign lastAcq    = (acqCnt == ACQ_W'(ACQS - 1));

    // ****************************************
    // counters
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel     <= '0;
            acqCnt    <= '0;
        end else if (accept) begin
            // nested wrap, all three back to zero after the last sample
            sampleCnt <= lastSample ? '0 : sampleCnt + 1'b1;
            if (lastSample) begin
                pixel <= lastPixel ? '0 : pixel + 1'b1;
                if (lastPixel) begin
                    acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                end
            end
        end
    end

    // ****************************************
    // collect / drain / turn
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= sifhPkg::ST_COLLECT;
            pass     <= sifhPkg::PASS_COARSE;
            drainCnt <= '0;
        end else begin
            case (state)
                sifhPkg::ST_COLLECT: begin
                    if (accept && lastSample && lastPixel && lastAcq) begin
                        state    <= sifhPkg::ST_DRAIN;
                        drainCnt <= '0;
                    end
                end
                sifhPkg::ST_DRAIN: begin
                    // three cycles to empty the filter, histogram and peak stages
                    drainCnt <= drainCnt + 1'b1;
                    if (drainCnt == 2'd2) begin
                        state <= sifhPkg::ST_TURN;
                    end
                end
                sifhPkg::ST_TURN: begin
                    state <= sifhPkg::ST_COLLECT;
                    pass  <= (pass == sifhPkg::PASS_COARSE) ? sifhPkg::PASS_FINE
                                                            : sifhPkg::PASS_COARSE;
                end
                default: begin
                    state <= sifhPkg::ST_COLLECT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dataFilter.sv ====
// data filter stage
// timestamp to bin address with fine window rejection
`timescale 1ns/100ps
`default_nettype none

module dataFilter #(
    parameter int NP        = sifhPkg::NP_DEF,
    parameter int NB        = sifhPkg::NB_DEF,
    parameter int PIXELS    = sifhPkg::PIXELS_DEF,
    localparam int PIX_W    = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             accept,
    input  logic [NP-1:0]    data,
    input  sifhPkg::passE    pass,
    input  logic [PIX_W-1:0] pixel,
    input  logic [NP-1:0]    winLo,
    output logic             valid,
    output logic [PIX_W-1:0] pixelOut,
    output logic [NB-1:0]    bin
);

    // offset into the window, one extra bit for the sign
    logic [NP:0]   offset;
    logic          inWin;
    logic [NB-1:0] binNext;

    assign offset  = {1'b0, data} - {1'b0, winLo};
    // no borrow and nothing above the window width
    assign inWin   = (offset[NP:NB] == '0);
    // coarse bin from the top bits
    assign binNext = (pass == sifhPkg::PASS_COARSE) ? data[NP-1 -: NB] : offset[NB-1:0];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            valid <= 1'b0;
        end else begin
            valid <= accept & ((pass == sifhPkg::PASS_COARSE) | inWin);
        end
    end

    // payload
    always_ff @(posedge clk) begin
        pixelOut <= pixel;
        bin      <= binNext;
    end

endmodule

`default_nettype wire

// ==== rtl/histBuilder.sv ====
// histogram builder
// per-pixel bin counts with valid flags and read-increment-write
`timescale 1ns/100ps
`default_nettype none

module histBuilder #(
    parameter int NB        = sifhPkg::NB_DEF,
    parameter int PIXELS    = sifhPkg::PIXELS_DEF,
    parameter int COUNT_W   = sifhPkg::COUNT_W_DEF,
    localparam int PIX_W    = (PIXELS > 1) ? $clog2(PIXELS) : 1,
    localparam int BINS     = 2 ** NB
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             valid,
    input  logic [PIX_W-1:0] pixel,
    input  logic [NB-1:0]    bin,
    input  logic             clearStat,
    binIf.src                upd
);

    logic [COUNT_W-1:0] counts [PIXELS][BINS];
    // flag low means the stored count is stale
    logic [BINS-1:0]    binUsed [PIXELS];
    logic [COUNT_W-1:0] curCount;
    logic [COUNT_W-1:0] nextCount;

    // combinational read so back-to-back hits see the last write
    assign curCount  = binUsed[pixel][bin] ? counts[pixel][bin] : '0;
    assign nextCount = curCount + 1'b1;

    always_ff @(posedge clk) begin
        if (valid) begin
            counts[pixel][bin] <= nextCount;
        end
    end

    // single-cycle clear of the whole histogram
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binUsed <= '{default: '0};
        end else if (clearStat) begin
            binUsed <= '{default: '0};
        end else if (valid) begin
            binUsed[pixel][bin] <= 1'b1;
        end
    end

    // ****************************************
    // update to the peak detector
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            upd.valid <= 1'b0;
        end else begin
            upd.valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        upd.pixel <= pixel;
        upd.bin   <= bin;
        upd.count <= nextCount;
    end

endmodule

`default_nettype wire

// ==== rtl/peakDetector.sv ====
// peak detector
// running per-pixel maximum count and its bin
`timescale 1ns/100ps
`default_nettype none

module peakDetector #(
    parameter int NB        = sifhPkg::NB_DEF,
    parameter int PIXELS    = sifhPkg::PIXELS_DEF,
    parameter int COUNT_W   = sifhPkg::COUNT_W_DEF
) (
    input  logic                 clk,
    input  logic                 combin_res,
    binIf.dst                    upd,
    input  logic                 clearStat,
    output logic [PIXELS*NB-1:0] peakBins
);

    logic [COUNT_W-1:0] maxCount [PIXELS];
    logic [NB-1:0]      maxBin [PIXELS];
    logic               isHigher;

    // strictly greater, first bin to reach a count keeps it
    assign isHigher = (upd.count > maxCount[upd.pixel]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCount <= '{default: '0};
            maxBin   <= '{default: '0};
        end else if (clearStat) begin
            // untouched pixel reports bin 0
            maxCount <= '{default: '0};
            maxBin   <= '{default: '0};
        end else if (upd.valid && isHigher) begin
            maxCount[upd.pixel] <= upd.count;
            maxBin[upd.pixel]   <= upd.bin;
        end
    end

    // ****************************************
    // pack peaks, pixel 0 in the low bits
    // ****************************************
    for (genvar p = 0; p < PIXELS; p++) begin : gPack
        assign peakBins[p*NB +: NB] = maxBin[p];
    end

endmodule

`default_nettype wire

// ==== rtl/windowCalc.sv ====
// window calculation
// fine window edges from coarse peaks and final result assembly
`timescale 1ns/100ps
`default_nettype none

module windowCalc #(
    parameter int NP        = sifhPkg::NP_DEF,
    parameter int NB        = sifhPkg::NB_DEF,
    parameter int PIXELS    = sifhPkg::PIXELS_DEF,
    localparam int PIX_W    = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  sifhPkg::passE        pass,
    input  logic                 passEnd,
    input  logic [PIXELS*NB-1:0] peakBins,
    input  logic [PIX_W-1:0]     pixel,
    output logic [NP-1:0]        winLo,
    output logic [PIXELS*NP-1:0] result,
    output logic                 resultValid
);

    // half a coarse bin, half a window, and the highest legal low edge
    localparam logic [NP:0] HALF_C = {{NP{1'b0}}, 1'b1} << (NP - NB - 1);
    localparam logic [NP:0] HALF_W = {{NP{1'b0}}, 1'b1} << (NB - 1);
    localparam logic [NP:0] LO_MAX = {1'b0, {NP{1'b1}}} - ({{NP{1'b0}}, 1'b1} << NB) + 1'b1;

    logic [NP-1:0] winLoArr [PIXELS];

    // coarse bin centre minus half a window, clamped into range
    function automatic logic [NP-1:0] calcLo(input logic [NB-1:0] coarse);
        logic [NP:0] centre;
        logic [NP:0] lo;
        centre = {1'b0, coarse, {(NP - NB){1'b0}}} + HALF_C;
        if (centre < HALF_W) begin
            lo = '0;
        end else begin
            lo = centre - HALF_W;
        end
        if (lo > LO_MAX) begin
            lo = LO_MAX;
        end
        return lo[NP-1:0];
    endfunction

    assign winLo = winLoArr[pixel];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLoArr    <= '{default: '0};
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= passEnd & (pass == sifhPkg::PASS_FINE);
            for (int p = 0; p < PIXELS; p++) begin
                if (passEnd && pass == sifhPkg::PASS_COARSE) begin
                    winLoArr[p] <= calcLo(peakBins[p*NB +: NB]);
                end
                // low edge plus fine peak offset
                if (passEnd && pass == sifhPkg::PASS_FINE) begin
                    result[p*NP +: NP] <= winLoArr[p]
                                        + {{(NP - NB){1'b0}}, peakBins[p*NB +: NB]};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sifhTop.sv ====
// SiFH peak finder top level
// frame control and the filter, histogram, peak and window datapath
`timescale 1ns/100ps
`default_nettype none

module sifhTop #(
    parameter int NP        = sifhPkg::NP_DEF,
    parameter int NB        = sifhPkg::NB_DEF,
    parameter int PIXELS    = sifhPkg::PIXELS_DEF,
    parameter int SAMPLES   = sifhPkg::SAMPLES_DEF,
    parameter int ACQS      = sifhPkg::ACQS_DEF,
    parameter int COUNT_W   = sifhPkg::COUNT_W_DEF,
    localparam int PIX_W    = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 wrEn,
    input  logic [NP-1:0]        data,
    output logic                 ready,
    output logic [PIXELS*NP-1:0] result,
    output logic                 resultValid
);

    // control
    logic               accept;
    logic [PIX_W-1:0]   pixel;
    sifhPkg::passE      pass;
    logic               passEnd;
    logic               clearStat;
    // filter output
    logic               fltValid;
    logic [PIX_W-1:0]   fltPixel;
    logic [NB-1:0]      fltBin;
    // window feedback
    logic [PIXELS*NB-1:0] peakBins;
    logic [NP-1:0]        winLo;

    binIf #(.PIX_W(PIX_W), .NB(NB), .COUNT_W(COUNT_W)) upd ();

    // ****************************************
    // control
    // ****************************************
    frameControl #(.PIXELS(PIXELS), .SAMPLES(SAMPLES), .ACQS(ACQS)) frameControl_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .ready      (ready),
        .accept     (accept),
        .pixel      (pixel),
        .pass       (pass),
        .passEnd    (passEnd),
        .clearStat  (clearStat)
    );

    // ****************************************
    // datapath
    // ****************************************
    dataFilter #(.NP(NP), .NB(NB), .PIXELS(PIXELS)) dataFilter_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .accept     (accept),
        .data       (data),
        .pass       (pass),
        .pixel      (pixel),
        .winLo      (winLo),
        .valid      (fltValid),
        .pixelOut   (fltPixel),
        .bin        (fltBin)
    );

    histBuilder #(.NB(NB), .PIXELS(PIXELS), .COUNT_W(COUNT_W)) histBuilder_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .valid      (fltValid),
        .pixel      (fltPixel),
        .bin        (fltBin),
        .clearStat  (clearStat),
        .upd        (upd.src)
    );

    peakDetector #(.NB(NB), .PIXELS(PIXELS), .COUNT_W(COUNT_W)) peakDetector_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .upd        (upd.dst),
        .clearStat  (clearStat),
        .peakBins   (peakBins)
    );

    windowCalc #(.NP(NP), .NB(NB), .PIXELS(PIXELS)) windowCalc_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .pass        (pass),
        .passEnd     (passEnd),
        .peakBins    (peakBins),
        .pixel       (pixel),
        .winLo       (winLo),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// ==== testbench/sifhTop_checker.sv ====
// concurrent checks on the peak finder top-level ports
// result pulse width, pulse placement and reset levels
`timescale 1ns/100ps
`default_nettype none

module sifhTop_checker (
    input  logic clk,
    input  logic combin_res,
    input  logic ready,
    input  logic resultValid
);

    // ****************************************
    // result strobe
    // ****************************************

    // one-cycle pulse per frame
    resultPulse: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |=> !resultValid)
        else $error("resultValid stayed high for more than one cycle");

    // pulse follows the turn cycle, never a collect cycle
    resultAfterTurn: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(resultValid) |-> $past(!ready))
        else $error("resultValid rose while samples were being collected");

    // ****************************************
    // reset levels
    // ****************************************
    resetLevels: assert property (@(posedge clk)
        !combin_res |-> (ready && !resultValid))
        else $error("ready or resultValid wrong while in reset");

endmodule

`default_nettype wire

// ==== testbench/sifhTb.sv ====
// testbench for the SiFH peak finder top level
// seeded stimulus, two-pass reference model, compare tasks and watchdog
`timescale 1ns/100ps
`default_nettype none

module sifhTb;

    localparam int NP           = sifhPkg::NP_DEF;
    localparam int NB           = sifhPkg::NB_DEF;
    localparam int PIXELS       = sifhPkg::PIXELS_DEF;
    localparam int SAMPLES      = sifhPkg::SAMPLES_DEF;
    localparam int ACQS         = sifhPkg::ACQS_DEF;
    localparam int COUNT_W      = sifhPkg::COUNT_W_DEF;
    localparam int FRAMES       = 4;
    localparam int PASS_SAMPLES = ACQS * PIXELS * SAMPLES;
    localparam int CLK_NS       = 20;
    localparam int WATCHDOG_NS  = (FRAMES * 2 * PASS_SAMPLES * 4 + 200) * CLK_NS;
    localparam int TS_MAX       = (1 << NP) - 1;
    // LSBs per coarse bin, as a shift
    localparam int COARSE_SHIFT = NP - NB;

    logic                 clk;
    logic                 combin_res;
    logic                 wrEn;
    logic [NP-1:0]        data;
    logic                 ready;
    logic [PIXELS*NP-1:0] result;
    logic                 resultValid;

    integer seed;
    int     targets [PIXELS];
    // one pass in arrival order
    int     passData [PASS_SAMPLES];
    int     winLoModel [PIXELS];
    int     expResult [PIXELS];

    sifhTop #(
        .NP      (NP),
        .NB      (NB),
        .PIXELS  (PIXELS),
        .SAMPLES (SAMPLES),
        .ACQS    (ACQS),
        .COUNT_W (COUNT_W)
    ) sifhTop_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .ready       (ready),
        .result      (result),
        .resultValid (resultValid)
    );

    bind sifhTop sifhTop_checker sifhTop_checker_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .ready       (ready),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic checkResult(input string name, input logic [NP-1:0] actual,
                               input logic [NP-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic checkLevel(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %b actual %b",
                     $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "level mismatch on %s", name);
        end
    endtask

    // ****************************************
    // reference model
    // ****************************************

    // coarse bin centre less half a window, kept inside the timestamp range
    function automatic int windowLow(input int coarse);
        int lo;
        lo = coarse * (1 << COARSE_SHIFT) + (1 << (COARSE_SHIFT - 1)) - (1 << (NB - 1));
        if (lo < 0) begin
            lo = 0;
        end
        if (lo > (1 << NP) - (1 << NB)) begin
            lo = (1 << NP) - (1 << NB);
        end
        return lo;
    endfunction

    // histogram one pixel of the stored pass, first bin to a count wins ties
    function automatic int findPeak(input int p, input bit fine);
        int hist [1 << NB];
        int maxCount;
        int maxBin;
        int b;
        int d;
        maxCount = 0;
        maxBin   = 0;
        foreach (hist[i]) begin
            hist[i] = 0;
        end
        for (int k = 0; k < PASS_SAMPLES; k++) begin
            if ((k / SAMPLES) % PIXELS == p) begin
                d = passData[k];
                if (!fine) begin
                    b = d / (1 << COARSE_SHIFT);
                end else if (d >= winLoModel[p] && d < winLoModel[p] + (1 << NB)) begin
                    b = d - winLoModel[p];
                end else begin
                    // outside the fine window
                    b = -1;
                end
                if (b >= 0) begin
                    hist[b]++;
                    if (hist[b] > maxCount) begin
                        maxCount = hist[b];
                        maxBin   = b;
                    end
                end
            end
        end
        return maxBin;
    endfunction

    // ****************************************
    // stimulus
    // ****************************************

    // mostly near the target, one in four uniform noise
    function automatic int pickSample(input int target);
        int v;
        if (({$random(seed)} % 4) == 0) begin
            v = {$random(seed)} % (TS_MAX + 1);
        end else begin
            v = target + $random(seed) % 13;
        end
        if (v < 0) begin
            v = 0;
        end
        if (v > TS_MAX) begin
            v = TS_MAX;
        end
        return v;
    endfunction

    task automatic chooseTargets(input int frame);
        for (int p = 0; p < PIXELS; p++) begin
            targets[p] = {$random(seed)} % (TS_MAX + 1);
        end
        // range edges, coarse peaks in the first and last bins
        if (frame == 1) begin
            targets[0]          = 2;
            targets[PIXELS - 1] = TS_MAX - 1;
        end
        if (frame == 2) begin
            targets[1] = 0;
            targets[2] = TS_MAX;
        end
    endtask

    task automatic fillPass();
        for (int k = 0; k < PASS_SAMPLES; k++) begin
            passData[k] = pickSample(targets[(k / SAMPLES) % PIXELS]);
        end
    endtask

    // one sample, after a random number of idle cycles
    task automatic sendSample(input int value);
        bit sent;
        sent = 1'b0;
        while (!sent) begin
            @(negedge clk);
            checkLevel("ready", ready, 1'b1);
            checkLevel("resultValid", resultValid, 1'b0);
            if (({$random(seed)} % 5) == 0) begin
                wrEn = 1'b0;
            end else begin
                wrEn = 1'b1;
                data = value[NP-1:0];
                sent = 1'b1;
            end
        end
    endtask

    // drain and turn, with strobes while ready is low
    task automatic endPass(input bit fine);
        int          n;
        logic [31:0] rnd;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            // back to collect four edges after the accepting edge
            checkLevel("ready", ready, n >= 5);
            checkLevel("resultValid", resultValid, fine && n == 5);
            if (!ready) begin
                rnd  = $random(seed);
                wrEn = rnd[0];
                data = rnd[NP:1];
            end else begin
                wrEn = 1'b0;
            end
        end while (!ready);
        if (fine) begin
            for (int p = 0; p < PIXELS; p++) begin
                checkResult($sformatf("result[%0d]", p), result[p*NP +: NP],
                            expResult[p][NP-1:0]);
            end
        end
    endtask

    task automatic drivePass(input bit fine);
        for (int k = 0; k < PASS_SAMPLES; k++) begin
            sendSample(passData[k]);
        end
        endPass(fine);
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        seed       = 33288;
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        repeat (5) @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);
        checkLevel("ready", ready, 1'b1);
        checkLevel("resultValid", resultValid, 1'b0);
        for (int p = 0; p < PIXELS; p++) begin
            checkResult($sformatf("result[%0d]", p), result[p*NP +: NP], '0);
        end
        for (int f = 0; f < FRAMES; f++) begin
            chooseTargets(f);
            // coarse pass fixes the windows
            fillPass();
            for (int p = 0; p < PIXELS; p++) begin
                winLoModel[p] = windowLow(findPeak(p, 1'b0));
            end
            drivePass(1'b0);
            // fine pass on a fresh sweep
            fillPass();
            for (int p = 0; p < PIXELS; p++) begin
                expResult[p] = winLoModel[p] + findPeak(p, 1'b1);
            end
            drivePass(1'b1);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("run timed out before all frames were processed");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/sifhPkg.sv
rtl/binIf.sv
rtl/frameControl.sv
rtl/dataFilter.sv
rtl/histBuilder.sv
rtl/peakDetector.sv
rtl/windowCalc.sv
rtl/sifhTop.sv
testbench/sifhTop_checker.sv
testbench/sifhTb.sv

// ==== run.sh ====
#!/bin/sh
# compile the SiFH peak finder testbench with Verilator and run it
# the run counts as passed only if the pass message shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module sifhTb \
    -f filelist.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
